/* Makefile */
# Verilator build and run of the multiply unit testbench

VERILATOR ?= verilator
TOP       ?= mult_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --timescale $(TIMESCALE)

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(FILELIST) $(wildcard rtl/*.sv) $(wildcard verification/*.sv verification/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR TIMESCALE VFLAGS"

$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
test: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+verification
rtl/mult_pkg.sv
rtl/mult_lane_if.sv
rtl/mult_issue.sv
rtl/mult_stage.sv
rtl/mult_result.sv
rtl/mult_unit.sv
verification/mult_tb.sv

/* rtl/mult_issue.sv */
module mult_issue (
  input  logic                   issue_valid,
  input  mult_pkg::word_t        opa_value,
  input  mult_pkg::word_t        opb_value,
  input  mult_pkg::opb_select_e  opb_select,
  input  mult_pkg::lit_t         literal,
  input  mult_pkg::rob_idx_t     rob_idx,
  input  mult_pkg::phys_reg_t    dest_tag,
  input  logic                   advance,
  mult_lane_if.source            lane
);

  mult_pkg::word_t lit_ext;
  mult_pkg::word_t mcand;

  // Literal is zero-extended to full width
  assign lit_ext = {{(mult_pkg::WORD_BITS - mult_pkg::LIT_BITS){1'b0}}, literal};

  always_comb begin
    case (opb_select)
      mult_pkg::OPB_IS_REGB: mcand = opb_value;
      mult_pkg::OPB_IS_IMM:  mcand = lit_ext;
      default:               mcand = opb_value;
    endcase
  end

  // Only accepted operations enter the first stage
  assign lane.valid    = issue_valid && advance;
  assign lane.product  = '0;
  assign lane.mplier   = opa_value;
  assign lane.mcand    = mcand;
  assign lane.rob_idx  = rob_idx;
  assign lane.dest_tag = dest_tag;

endmodule

/* rtl/mult_lane_if.sv */
interface mult_lane_if;

  logic                 valid;
  mult_pkg::word_t      product;  // Partial sum so far
  mult_pkg::word_t      mplier;   // Remaining multiplier bits
  mult_pkg::word_t      mcand;    // Multiplicand aligned to next slice
  mult_pkg::rob_idx_t   rob_idx;
  mult_pkg::phys_reg_t  dest_tag;

  modport source (
    output valid,
    output product,
    output mplier,
    output mcand,
    output rob_idx,
    output dest_tag
  );

  modport sink (
    input valid,
    input product,
    input mplier,
    input mcand,
    input rob_idx,
    input dest_tag
  );

endinterface

/* rtl/mult_pkg.sv */
package mult_pkg;

  // Operand and datapath widths
  localparam int WORD_BITS  = 64;
  localparam int NUM_STAGES = 4;
  localparam int SLICE_BITS = WORD_BITS / NUM_STAGES; // Multiplier bits per stage

  localparam int NUM_ROB  = 32;
  localparam int ROB_BITS = $clog2(NUM_ROB);
  localparam int NUM_PR   = 64;
  localparam int PR_BITS  = $clog2(NUM_PR);
  localparam int LIT_BITS = 8;

  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [ROB_BITS-1:0]  rob_idx_t;
  typedef logic [PR_BITS-1:0]   phys_reg_t;
  typedef logic [LIT_BITS-1:0]  lit_t;

  // Source of operand B
  typedef enum logic [0:0] {
    OPB_IS_REGB = 1'b0,
    OPB_IS_IMM  = 1'b1
  } opb_select_e;

  // True when an entry lies between the rollback point and the ROB tail,
  // both ends included. Distances wrap with the ROB index width.
  function automatic logic rob_squashed(
    input logic     rollback_en,
    input rob_idx_t entry_idx,
    input rob_idx_t rollback_idx,
    input rob_idx_t tail_idx
  );
    rob_idx_t entry_dist;
    rob_idx_t tail_dist;
    entry_dist = entry_idx - rollback_idx;
    tail_dist  = tail_idx - rollback_idx;
    return rollback_en && (entry_dist <= tail_dist);
  endfunction

endpackage

/* rtl/mult_result.sv */
module mult_result (
  input  logic                 clock,
  input  logic                 reset,
  mult_lane_if.sink            lane,
  input  logic                 cdb_grant,
  input  logic                 rollback_en,
  input  mult_pkg::rob_idx_t   rollback_rob_idx,
  input  mult_pkg::rob_idx_t   rob_tail_idx,
  output logic                 advance,
  output logic                 done,
  output mult_pkg::word_t      result,
  output mult_pkg::rob_idx_t   result_rob_idx,
  output mult_pkg::phys_reg_t  result_dest_tag
);

  logic                 held_q;
  mult_pkg::word_t      result_q;
  mult_pkg::rob_idx_t   rob_idx_q;
  mult_pkg::phys_reg_t  dest_tag_q;

  logic                 next_held;
  mult_pkg::rob_idx_t   next_rob_idx;
  logic                 squash;

  // Whole pipeline moves only if this slot is free or leaving
  assign advance = !held_q || cdb_grant;

  assign next_held    = advance ? lane.valid : held_q;
  assign next_rob_idx = advance ? lane.rob_idx : rob_idx_q;
  assign squash       = mult_pkg::rob_squashed(rollback_en, next_rob_idx,
                                               rollback_rob_idx, rob_tail_idx);

  always_ff @(posedge clock) begin
    if (reset) begin
      held_q <= 1'b0;
    end else begin
      held_q <= next_held && !squash;
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      result_q   <= lane.product; // Final partial sum is the product
      rob_idx_q  <= lane.rob_idx;
      dest_tag_q <= lane.dest_tag;
    end
  end

  // Offered to the bus until granted
  assign done            = held_q;
  assign result          = result_q;
  assign result_rob_idx  = rob_idx_q;
  assign result_dest_tag = dest_tag_q;

endmodule

/* rtl/mult_stage.sv */
module mult_stage (
  input  logic                clock,
  input  logic                reset,
  input  logic                advance,
  input  logic                rollback_en,
  input  mult_pkg::rob_idx_t  rollback_rob_idx,
  input  mult_pkg::rob_idx_t  rob_tail_idx,
  mult_lane_if.sink           up,
  mult_lane_if.source         down
);

  logic                 valid_q;
  mult_pkg::word_t      product_q;
  mult_pkg::word_t      mplier_q;
  mult_pkg::word_t      mcand_q;
  mult_pkg::rob_idx_t   rob_idx_q;
  mult_pkg::phys_reg_t  dest_tag_q;

  logic [mult_pkg::SLICE_BITS-1:0] slice;
  mult_pkg::word_t                 partial;
  mult_pkg::word_t                 next_product;
  logic                            next_valid;
  mult_pkg::rob_idx_t              next_rob_idx;
  logic                            squash;

  assign slice        = up.mplier[mult_pkg::SLICE_BITS-1:0];
  assign partial      = slice * up.mcand; // Low word only
  assign next_product = up.product + partial;

  // Squash looks at whatever this stage will hold after the edge
  assign next_valid   = advance ? up.valid : valid_q;
  assign next_rob_idx = advance ? up.rob_idx : rob_idx_q;
  assign squash       = mult_pkg::rob_squashed(rollback_en, next_rob_idx,
                                               rollback_rob_idx, rob_tail_idx);

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= next_valid && !squash;
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      product_q  <= next_product;
      mplier_q   <= up.mplier >> mult_pkg::SLICE_BITS;
      mcand_q    <= up.mcand << mult_pkg::SLICE_BITS;
      rob_idx_q  <= up.rob_idx;
      dest_tag_q <= up.dest_tag;
    end
  end

  assign down.valid    = valid_q;
  assign down.product  = product_q;
  assign down.mplier   = mplier_q;
  assign down.mcand    = mcand_q;
  assign down.rob_idx  = rob_idx_q;
  assign down.dest_tag = dest_tag_q;

endmodule

/* rtl/mult_unit.sv */
module mult_unit (
  input  logic                   clock,
  input  logic                   reset,

  input  logic                   issue_valid,
  output logic                   issue_ready,
  input  mult_pkg::word_t        opa_value,
  input  mult_pkg::word_t        opb_value,
  input  mult_pkg::opb_select_e  opb_select,
  input  mult_pkg::lit_t         literal,
  input  mult_pkg::rob_idx_t     rob_idx,
  input  mult_pkg::phys_reg_t    dest_tag,

  input  logic                   cdb_grant,
  input  logic                   rollback_en,
  input  mult_pkg::rob_idx_t     rollback_rob_idx,
  input  mult_pkg::rob_idx_t     rob_tail_idx,

  output logic                   done,
  output mult_pkg::word_t        result,
  output mult_pkg::rob_idx_t     result_rob_idx,
  output mult_pkg::phys_reg_t    result_dest_tag
);

  logic advance;

  // Hop 0 from issue, hop NUM_STAGES into the result slot
  mult_lane_if hop [0:mult_pkg::NUM_STAGES] ();

  assign issue_ready = advance;

  mult_issue i_issue (
    .issue_valid (issue_valid),
    .opa_value   (opa_value),
    .opb_value   (opb_value),
    .opb_select  (opb_select),
    .literal     (literal),
    .rob_idx     (rob_idx),
    .dest_tag    (dest_tag),
    .advance     (advance),
    .lane        (hop[0])
  );

  for (genvar i = 0; i < mult_pkg::NUM_STAGES; i++) begin : g_stage
    mult_stage i_stage (
      .clock            (clock),
      .reset            (reset),
      .advance          (advance),
      .rollback_en      (rollback_en),
      .rollback_rob_idx (rollback_rob_idx),
      .rob_tail_idx     (rob_tail_idx),
      .up               (hop[i]),
      .down             (hop[i+1])
    );
  end

  mult_result i_result (
    .clock            (clock),
    .reset            (reset),
    .lane             (hop[mult_pkg::NUM_STAGES]),
    .cdb_grant        (cdb_grant),
    .rollback_en      (rollback_en),
    .rollback_rob_idx (rollback_rob_idx),
    .rob_tail_idx     (rob_tail_idx),
    .advance          (advance),
    .done             (done),
    .result           (result),
    .result_rob_idx   (result_rob_idx),
    .result_dest_tag  (result_dest_tag)
  );

endmodule

/* verification/mult_scoreboard.svh */
`ifndef MULT_SCOREBOARD_SVH
`define MULT_SCOREBOARD_SVH

typedef struct packed {
  mult_pkg::word_t     product;
  mult_pkg::rob_idx_t  rob_idx;
  mult_pkg::phys_reg_t dest_tag;
} expect_t;

expect_t model_q[$]; // Oldest operation at the front

// Low word of A times the selected operand B
function automatic mult_pkg::word_t expected_product(
  input mult_pkg::word_t       a,
  input mult_pkg::word_t       b,
  input mult_pkg::opb_select_e sel,
  input mult_pkg::lit_t        lit
);
  mult_pkg::word_t operand_b;
  if (sel == mult_pkg::OPB_IS_IMM) begin
    operand_b = '0;
    operand_b[mult_pkg::LIT_BITS-1:0] = lit; // Zero-extended literal
  end else begin
    operand_b = b;
  end
  return a * operand_b;
endfunction

// Entry lies between rollback point and tail, both inclusive
function automatic bit in_rollback_range(
  input mult_pkg::rob_idx_t idx,
  input mult_pkg::rob_idx_t rb,
  input mult_pkg::rob_idx_t tail
);
  int entry_dist;
  int tail_dist;
  entry_dist = (int'(idx) - int'(rb) + mult_pkg::NUM_ROB) % mult_pkg::NUM_ROB;
  tail_dist  = (int'(tail) - int'(rb) + mult_pkg::NUM_ROB) % mult_pkg::NUM_ROB;
  return entry_dist <= tail_dist;
endfunction

task automatic prune_rollback(input mult_pkg::rob_idx_t rb, input mult_pkg::rob_idx_t tail);
  expect_t kept[$];
  foreach (model_q[i]) begin
    if (in_rollback_range(model_q[i].rob_idx, rb, tail)) begin
      squashed++;
    end else begin
      kept.push_back(model_q[i]);
    end
  end
  model_q = kept;
endtask

task automatic compare_word(input string name, input mult_pkg::word_t expected,
                            input mult_pkg::word_t got);
  if (got !== expected) begin
    $display("Fail %s expected %h got %h", name, expected, got);
    abort_run();
  end
endtask

task automatic compare_rob(input string name, input mult_pkg::rob_idx_t expected,
                           input mult_pkg::rob_idx_t got);
  if (got !== expected) begin
    $display("Fail %s expected %h got %h", name, expected, got);
    abort_run();
  end
endtask

task automatic compare_tag(input string name, input mult_pkg::phys_reg_t expected,
                           input mult_pkg::phys_reg_t got);
  if (got !== expected) begin
    $display("Fail %s expected %h got %h", name, expected, got);
    abort_run();
  end
endtask

task automatic compare_flag(input string name, input logic expected, input logic got);
  if (got !== expected) begin
    $display("Fail %s expected %h got %h", name, expected, got);
    abort_run();
  end
endtask

`endif

/* verification/mult_tb.sv */
module mult_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_OPS     = 400;
  localparam int CYCLE_LIMIT = NUM_OPS * (mult_pkg::NUM_STAGES + 8) + 100;

  logic                  clock;
  logic                  reset;
  logic                  issue_valid;
  logic                  issue_ready;
  mult_pkg::word_t       opa_value;
  mult_pkg::word_t       opb_value;
  mult_pkg::opb_select_e opb_select;
  mult_pkg::lit_t        literal;
  mult_pkg::rob_idx_t    rob_idx;
  mult_pkg::phys_reg_t   dest_tag;
  logic                  cdb_grant;
  logic                  rollback_en;
  mult_pkg::rob_idx_t    rollback_rob_idx;
  mult_pkg::rob_idx_t    rob_tail_idx;
  logic                  done;
  mult_pkg::word_t       result;
  mult_pkg::rob_idx_t    result_rob_idx;
  mult_pkg::phys_reg_t   result_dest_tag;

  integer             seed;
  int                 cycle_count;
  int                 issued;   // Accepted operations, squashed ones included
  int                 squashed;
  mult_pkg::rob_idx_t next_rob;
  mult_pkg::rob_idx_t last_rob;

  task automatic abort_run();
    $display("Errors found");
    $fatal(1);
  endtask

  `include "mult_scoreboard.svh"

  mult_unit i_dut (
    .clock            (clock),
    .reset            (reset),
    .issue_valid      (issue_valid),
    .issue_ready      (issue_ready),
    .opa_value        (opa_value),
    .opb_value        (opb_value),
    .opb_select       (opb_select),
    .literal          (literal),
    .rob_idx          (rob_idx),
    .dest_tag         (dest_tag),
    .cdb_grant        (cdb_grant),
    .rollback_en      (rollback_en),
    .rollback_rob_idx (rollback_rob_idx),
    .rob_tail_idx     (rob_tail_idx),
    .done             (done),
    .result           (result),
    .result_rob_idx   (result_rob_idx),
    .result_dest_tag  (result_dest_tag)
  );

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Run hung: not finished within %0d cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  task automatic randomize_operands();
    logic [31:0] r;
    opa_value  <= {$random(seed), $random(seed)};
    opb_value  <= {$random(seed), $random(seed)};
    r = $random(seed);
    opb_select <= r[0] ? mult_pkg::OPB_IS_IMM : mult_pkg::OPB_IS_REGB;
    literal    <= r[8 +: mult_pkg::LIT_BITS];
    dest_tag   <= r[16 +: mult_pkg::PR_BITS];
    rob_idx    <= next_rob;
  endtask

  task automatic drive_random();
    logic want_issue;
    logic want_rollback;
    int   pick;
    want_issue    = (({$random(seed)} % 100) < 70) && (issued < NUM_OPS);
    want_rollback = (({$random(seed)} % 100) < 4) && (model_q.size() > 0);
    randomize_operands();
    issue_valid  <= want_issue;
    cdb_grant    <= ({$random(seed)} % 100) < 60;
    rollback_en  <= want_rollback;
    rob_tail_idx <= want_issue ? next_rob : last_rob; // Tail covers a same-cycle issue
    if (want_rollback) begin
      pick = {$random(seed)} % model_q.size();
      rollback_rob_idx <= model_q[pick].rob_idx;
    end
  endtask

  task automatic drive_idle();
    issue_valid <= 1'b0;
    cdb_grant   <= 1'b1;
    rollback_en <= 1'b0;
  endtask

  // Inputs and outputs are settled here, ahead of the next rising edge
  task automatic observe_edge();
    expect_t item;
    logic    accepted;
    accepted = issue_valid && issue_ready;
    if (done) begin
      if (model_q.size() == 0) begin
        $display("Result offered on done with no operation outstanding");
        abort_run();
      end else begin
        // Offered result is the oldest outstanding operation until granted
        item = model_q[0];
        compare_word("result", item.product, result);
        compare_rob("result_rob_idx", item.rob_idx, result_rob_idx);
        compare_tag("result_dest_tag", item.dest_tag, result_dest_tag);
        if (cdb_grant) begin
          model_q.delete(0);
        end else begin
          compare_flag("issue_ready", 1'b0, issue_ready);
        end
      end
    end
    if (accepted) begin
      item.product  = expected_product(opa_value, opb_value, opb_select, literal);
      item.rob_idx  = rob_idx;
      item.dest_tag = dest_tag;
      model_q.push_back(item);
      issued++;
      last_rob = next_rob;
      next_rob = next_rob + 1'b1;
    end
    if (rollback_en) begin
      prune_rollback(rollback_rob_idx, rob_tail_idx);
      next_rob = rollback_rob_idx; // ROB refills from the rollback point
      last_rob = rollback_rob_idx - 1'b1;
    end
  endtask

  // Single operation with the bus always granting
  task automatic run_directed(input mult_pkg::opb_select_e sel);
    int edges;
    @(posedge clock);
    randomize_operands();
    opb_select  <= sel;
    issue_valid <= 1'b1;
    cdb_grant   <= 1'b1;
    rollback_en <= 1'b0;
    @(negedge clock);
    compare_flag("issue_ready", 1'b1, issue_ready);
    observe_edge();
    @(posedge clock); // Accepting edge
    issue_valid <= 1'b0;
    @(negedge clock);
    observe_edge();
    edges = 0;
    do begin
      @(posedge clock);
      edges++;
      @(negedge clock);
      observe_edge();
    end while (!done && edges < 4 * mult_pkg::NUM_STAGES);
    if (edges != mult_pkg::NUM_STAGES) begin
      $display("done rose %0d cycles after the accepting edge instead of %0d",
               edges, mult_pkg::NUM_STAGES);
      abort_run();
    end
  endtask

  initial begin
    seed             = 44;
    clock            = 1'b0;
    reset            = 1'b1;
    issue_valid      = 1'b0;
    opa_value        = '0;
    opb_value        = '0;
    opb_select       = mult_pkg::OPB_IS_REGB;
    literal          = '0;
    rob_idx          = '0;
    dest_tag         = '0;
    cdb_grant        = 1'b0;
    rollback_en      = 1'b0;
    rollback_rob_idx = '0;
    rob_tail_idx     = '0;
    cycle_count      = 0;
    issued           = 0;
    squashed         = 0;
    next_rob         = '0;
    last_rob         = '1;

    repeat (5) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    compare_flag("done", 1'b0, done);
    compare_flag("issue_ready", 1'b1, issue_ready);

    run_directed(mult_pkg::OPB_IS_REGB);
    run_directed(mult_pkg::OPB_IS_IMM);

    while (issued < NUM_OPS) begin
      @(posedge clock);
      drive_random();
      @(negedge clock);
      observe_edge();
    end

    // Drain, then make sure nothing else shows up
    while (model_q.size() != 0 || done) begin
      @(posedge clock);
      drive_idle();
      @(negedge clock);
      observe_edge();
    end
    repeat (mult_pkg::NUM_STAGES + 2) begin
      @(posedge clock);
      drive_idle();
      @(negedge clock);
      observe_edge();
    end

    $display("Issued %0d operations, %0d squashed by rollback", issued, squashed);
    if (model_q.size() == 0 && !done) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Operations still outstanding at the end of the run");
      abort_run();
    end
  end

endmodule
